//--- tb.f
design/soc_pkg.sv
design/riscv_pkg.sv
design/block_ram.sv
design/register_file.sv
design/insn_decoder.sv
design/reg_heartbeat.sv
design/rv_soc_top.sv
verification/rv_soc_asserts.sv
verification/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_top -Mdir "$build_dir" -o tb_top_sim -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/tb_top_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1

//--- verification/tb_top.sv
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cycles = 2000;

    typedef enum int {imm_none, imm_i, imm_s, imm_b, imm_u, imm_j} imm_kind_t;

    logic                                  clock;
    logic                                  rst_n;
    logic                                  led;
    soc_pkg::mem_port_t                    inst_ext;
    logic [soc_pkg::word_width-1:0]        inst_ext_data;
    soc_pkg::mem_port_t                    data_ext;
    logic [soc_pkg::word_width-1:0]        data_ext_data;
    logic [soc_pkg::reg_address_width-1:0] reg_ext_address;
    logic [soc_pkg::word_width-1:0]        reg_ext_data;
    riscv_pkg::insn_t                      insn_to_decode;
    riscv_pkg::decode_t                    decode;

    logic [31:0] lcg_state;
    int          cycle_count = 0;
    logic [15:0] ram_addresses [16];
    logic [31:0] inst_model [logic [15:0]];
    logic [31:0] data_model [logic [15:0]];

    rv_soc_top dut0 (
        .clock           (clock),
        .rst_n           (rst_n),
        .led             (led),
        .inst_ext        (inst_ext),
        .inst_ext_data   (inst_ext_data),
        .data_ext        (data_ext),
        .data_ext_data   (data_ext_data),
        .reg_ext_address (reg_ext_address),
        .reg_ext_data    (reg_ext_data),
        .insn_to_decode  (insn_to_decode),
        .decode          (decode)
    );

    bind rv_soc_top rv_soc_asserts asserts0 (
        .clock           (clock),
        .rst_n           (rst_n),
        .led             (led),
        .reg_ext_address (reg_ext_address),
        .reg_ext_data    (reg_ext_data),
        .op_class        (decode.op_class)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", max_cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] observed,
                               input logic [31:0] expected);
        if (observed !== expected) begin
            $display("ERROR at %0t ns: %s: got 0x%08h, expected 0x%08h",
                     $time, what, observed, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        rst_n <= 1'b0;
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;
    endtask

    task automatic drive_mem(input bit use_data, input logic [15:0] address,
                             input logic write, input logic [31:0] data);
        soc_pkg::mem_port_t port;
        port = '{address: address, write: write, data: data};
        @(posedge clock);
        if (use_data) begin
            data_ext <= port;
        end else begin
            inst_ext <= port;
        end
    endtask

    // Data is registered, so it shows up one edge after the address.
    task automatic read_mem(input bit use_data, input logic [15:0] address,
                            output logic [31:0] value);
        drive_mem(use_data, address, 1'b0, '0);
        @(posedge clock);
        @(negedge clock);
        value = use_data ? data_ext_data : inst_ext_data;
    endtask

    task automatic read_reg_ext(input logic [4:0] address, output logic [31:0] value);
        @(posedge clock);
        reg_ext_address <= address;
        @(posedge clock);
        @(negedge clock);
        value = reg_ext_data;
    endtask

    // Field placement per instruction format.
    function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd,
            input logic [6:0] opcode);
        return {funct7, rs2, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] funct3, input logic [4:0] rd, input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] funct3, input logic [6:0] opcode);
        return {imm[11:5], rs2, rs1, funct3, imm[4:0], opcode};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] funct3, input logic [6:0] opcode);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opcode};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd,
            input logic [6:0] opcode);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcode};
    endfunction

    function automatic riscv_pkg::op_class_t class_for(input string name);
        riscv_pkg::op_class_t cls;
        cls = '0;
        case (name)
            "lw":       cls.is_load = 1'b1;
            "sw":       cls.is_store = 1'b1;
            "beq":      cls.is_branch = 1'b1;
            "jal":      cls.is_jal = 1'b1;
            "jalr":     cls.is_jalr = 1'b1;
            "lui":      cls.is_lui = 1'b1;
            "auipc":    cls.is_auipc = 1'b1;
            "addi":     cls.is_alu_reg_imm = 1'b1;
            "add":      cls.is_alu_reg_reg = 1'b1;
            "ecall":    cls.is_system = 1'b1;
            "fadd.s":   cls.is_fadd = 1'b1;
            "fsqrt.s":  cls.is_fsqrt = 1'b1;
            "fcvt.w.s": cls.is_fcvt_f2i = 1'b1;
            "fmv.x.w":  cls.is_fmv_f2i = 1'b1;
            "fcvt.s.w": cls.is_fcvt_i2f = 1'b1;
            "fmv.w.x":  cls.is_fmv_i2f = 1'b1;
            default:    cls = '0;
        endcase
        return cls;
    endfunction

    // A negative field value means the format has no such field.
    task automatic decode_case(input string name, input logic [31:0] word, input int rd,
                               input int rs1, input int rs2, input int funct3,
                               input int funct7, input imm_kind_t kind,
                               input logic [31:0] imm);
        logic [31:0] observed_imm;
        @(posedge clock);
        insn_to_decode <= word;
        @(negedge clock);
        check_value({name, " class"}, 32'(decode.op_class), 32'(class_for(name)));
        if (rd >= 0) begin
            check_value({name, " rd"}, 32'(decode.rd), rd);
        end
        if (rs1 >= 0) begin
            check_value({name, " rs1"}, 32'(decode.rs1), rs1);
        end
        if (rs2 >= 0) begin
            check_value({name, " rs2"}, 32'(decode.rs2), rs2);
            check_value({name, " shamt_ftype"}, 32'(decode.shamt_ftype), rs2);
        end
        if (funct3 >= 0) begin
            check_value({name, " funct3"}, 32'(decode.funct3_rm), funct3);
        end
        // R4 format reuses funct7 as rs3 over fmt.
        if (funct7 >= 0) begin
            check_value({name, " funct7"}, 32'(decode.funct7), funct7);
            check_value({name, " funct5"}, 32'(decode.funct5), funct7 >> 2);
            check_value({name, " rs3"}, 32'(decode.rs3), funct7 >> 2);
            check_value({name, " fmt"}, 32'(decode.fmt), funct7 & 3);
        end
        if (kind != imm_none) begin
            case (kind)
                imm_i: observed_imm = decode.imm_alu_load;
                imm_s: observed_imm = decode.imm_store;
                imm_b: observed_imm = decode.imm_branch;
                imm_u: observed_imm = decode.imm_upper;
                default: observed_imm = decode.imm_jump;
            endcase
            check_value({name, " immediate"}, observed_imm, imm);
        end
    endtask

    task automatic inst_ram_test();
        logic [31:0] word;
        logic [31:0] value;
        for (int i = 0; i < 16; i++) begin
            word = lcg_next();
            // Few low address bits, so some addresses repeat.
            ram_addresses[i] = {word[31:28], 9'd0, word[18:16]};
            word = lcg_next();
            inst_model[ram_addresses[i]] = word;
            drive_mem(1'b0, ram_addresses[i], 1'b1, word);
        end
        for (int i = 0; i < 16; i++) begin
            read_mem(1'b0, ram_addresses[i], value);
            check_value("inst_ram readback", value, inst_model[ram_addresses[i]]);
        end
        word = lcg_next();
        drive_mem(1'b0, ram_addresses[0], 1'b1, word);
        @(posedge clock);
        @(negedge clock);
        check_value("inst_ram old word during write", inst_ext_data,
                    inst_model[ram_addresses[0]]);
        inst_model[ram_addresses[0]] = word;
        drive_mem(1'b0, ram_addresses[0], 1'b0, '0);
    endtask

    task automatic data_ram_test();
        logic [31:0] word;
        logic [31:0] value;
        for (int i = 0; i < 16; i++) begin
            word = lcg_next();
            data_model[ram_addresses[i]] = word;
            drive_mem(1'b1, ram_addresses[i], 1'b1, word);
        end
        for (int i = 0; i < 16; i++) begin
            read_mem(1'b1, ram_addresses[i], value);
            check_value("data_ram readback", value, data_model[ram_addresses[i]]);
        end
        for (int i = 0; i < 16; i++) begin
            read_mem(1'b0, ram_addresses[i], value);
            check_value("inst_ram after data writes", value, inst_model[ram_addresses[i]]);
        end
    endtask

    task automatic decode_test();
        decode_case("lw", encode_i(12'hffc, 5'd2, 3'd2, 5'd5, 7'h03),
                    5, 2, -1, 2, -1, imm_i, 32'hffff_fffc);
        decode_case("sw", encode_s(12'hfec, 5'd6, 5'd3, 3'd2, 7'h23),
                    -1, 3, 6, 2, -1, imm_s, 32'hffff_ffec);
        decode_case("beq", encode_b(13'h1ff0, 5'd2, 5'd1, 3'd0, 7'h63),
                    -1, 1, 2, 0, -1, imm_b, 32'hffff_fff0);
        decode_case("jal", encode_j(21'h012344, 5'd1, 7'h6f),
                    1, -1, -1, -1, -1, imm_j, 32'h0001_2344);
        decode_case("jalr", encode_i(12'h00c, 5'd1, 3'd0, 5'd0, 7'h67),
                    0, 1, -1, 0, -1, imm_i, 32'h0000_000c);
        decode_case("lui", encode_u(20'habcde, 5'd7, 7'h37),
                    7, -1, -1, -1, -1, imm_u, 32'habcd_e000);
        decode_case("auipc", encode_u(20'h12345, 5'd8, 7'h17),
                    8, -1, -1, -1, -1, imm_u, 32'h1234_5000);
        decode_case("addi", encode_i(12'h7ff, 5'd9, 3'd0, 5'd9, 7'h13),
                    9, 9, -1, 0, -1, imm_i, 32'h0000_07ff);
        decode_case("add", encode_r(7'h00, 5'd12, 5'd11, 3'd0, 5'd10, 7'h33),
                    10, 11, 12, 0, 'h00, imm_none, '0);
        decode_case("ecall", 32'h0000_0073, 0, 0, -1, 0, -1, imm_i, '0);
        decode_case("fadd.s", encode_r(7'h00, 5'd3, 5'd2, 3'd7, 5'd1, 7'h53),
                    1, 2, 3, 7, 'h00, imm_none, '0);
        decode_case("fsqrt.s", encode_r(7'h2c, 5'd0, 5'd5, 3'd7, 5'd4, 7'h53),
                    4, 5, 0, 7, 'h2c, imm_none, '0);
        decode_case("fcvt.w.s", encode_r(7'h60, 5'd0, 5'd7, 3'd1, 5'd6, 7'h53),
                    6, 7, 0, 1, 'h60, imm_none, '0);
        decode_case("fmv.x.w", encode_r(7'h70, 5'd0, 5'd9, 3'd0, 5'd8, 7'h53),
                    8, 9, 0, 0, 'h70, imm_none, '0);
        decode_case("fcvt.s.w", encode_r(7'h68, 5'd0, 5'd11, 3'd7, 5'd10, 7'h53),
                    10, 11, 0, 7, 'h68, imm_none, '0);
        decode_case("fmv.w.x", encode_r(7'h78, 5'd0, 5'd13, 3'd0, 5'd12, 7'h53),
                    12, 13, 0, 0, 'h78, imm_none, '0);
    endtask

    task automatic heartbeat_test();
        logic [31:0] first;
        logic [31:0] second;
        read_reg_ext(5'd1, first);
        repeat (40) @(negedge clock);
        second = reg_ext_data;
        check_value("x1 increments over 40 cycles", second - first, 32'd10);
    endtask

    task automatic zero_reg_test();
        logic [31:0] value;
        read_reg_ext(5'd0, value);
        check_value("x0 read", value, '0);
        read_reg_ext(5'd5, value);
        check_value("x5 read", value, '0);
    endtask

    task automatic led_test();
        int   transitions;
        logic previous;
        apply_reset();
        @(negedge clock);
        previous = led;
        transitions = 0;
        repeat (64) begin
            @(negedge clock);
            if (led != previous) begin
                transitions++;
            end
            previous = led;
        end
        check_value("led transitions in 64 cycles", transitions, 32'd16);
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        inst_ext = '0;
        data_ext = '0;
        reg_ext_address = '0;
        insn_to_decode = '0;
        lcg_state = 32'd43;
        apply_reset();
        inst_ram_test();
        data_ram_test();
        decode_test();
        heartbeat_test();
        zero_reg_test();
        led_test();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/rv_soc_asserts.sv
`default_nettype none

module rv_soc_asserts (
    input logic                                  clock,
    input logic                                  rst_n,
    input logic                                  led,
    input logic [soc_pkg::reg_address_width-1:0] reg_ext_address,
    input logic [soc_pkg::word_width-1:0]        reg_ext_data,
    input riscv_pkg::op_class_t                  op_class
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0] run_cycles;

    // Cycles since reset, saturating.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            run_cycles <= '0;
        end else if (run_cycles != 4'hf) begin
            run_cycles <= run_cycles + 4'd1;
        end
    end

    one_class_flag: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(op_class))
        else $error("more than one instruction class flag is set");

    zero_reg_read: assert property (@(posedge clock) disable iff (!rst_n)
        (reg_ext_address == '0) |=> (reg_ext_data == '0))
        else $error("a read of x0 through reg_ext returned a nonzero word");

    // Flips at least once in any four cycles.
    led_toggles: assert property (@(posedge clock) disable iff (!rst_n)
        (run_cycles >= 4'd4) |-> (led != $past(led, 4)))
        else $error("led held its level for more than four cycles");

    led_holds: assert property (@(posedge clock) disable iff (!rst_n)
        (run_cycles >= 4'd4 && $changed(led)) |->
            ($past(led, 1) == $past(led, 2) && $past(led, 2) == $past(led, 3)
             && $past(led, 3) == $past(led, 4)))
        else $error("led changed less than four cycles after its previous change");

endmodule

`default_nettype wire

//--- design/rv_soc_top.sv
`default_nettype none

module rv_soc_top (
    input  logic                                   clock,
    input  logic                                   rst_n,
    output logic                                   led,

    input  soc_pkg::mem_port_t                     inst_ext,
    output logic [soc_pkg::word_width-1:0]         inst_ext_data,

    input  soc_pkg::mem_port_t                     data_ext,
    output logic [soc_pkg::word_width-1:0]         data_ext_data,

    input  logic [soc_pkg::reg_address_width-1:0]  reg_ext_address,
    output logic [soc_pkg::word_width-1:0]         reg_ext_data,

    input  riscv_pkg::insn_t                       insn_to_decode,
    output riscv_pkg::decode_t                     decode
);

    // Sequencer side of the register file.
    logic [soc_pkg::reg_address_width-1:0] reg2_address;
    logic [soc_pkg::word_width-1:0]        reg2_data;
    soc_pkg::reg_write_t                   reg_write;

    block_ram inst_ram (
        .clock     (clock),
        .rst_n     (rst_n),
        .port      (inst_ext),
        .read_data (inst_ext_data)
    );

    block_ram data_ram (
        .clock     (clock),
        .rst_n     (rst_n),
        .port      (data_ext),
        .read_data (data_ext_data)
    );

    register_file regs (
        .clock         (clock),
        .rst_n         (rst_n),
        .write_port    (reg_write),
        .read1_address (reg_ext_address),
        .read1_data    (reg_ext_data),
        .read2_address (reg2_address),
        .read2_data    (reg2_data)
    );

    insn_decoder decoder (
        .insn   (insn_to_decode),
        .decode (decode)
    );

    // Bumps x1 every four cycles.
    reg_heartbeat heartbeat (
        .clock        (clock),
        .rst_n        (rst_n),
        .read_address (reg2_address),
        .read_data    (reg2_data),
        .write_port   (reg_write),
        .led          (led)
    );

endmodule

`default_nettype wire

//--- design/reg_heartbeat.sv
`default_nettype none

module reg_heartbeat (
    input  logic                                   clock,
    input  logic                                   rst_n,
    output logic [soc_pkg::reg_address_width-1:0]  read_address,
    input  logic [soc_pkg::word_width-1:0]         read_data,
    output soc_pkg::reg_write_t                    write_port,
    output logic                                   led
);

    logic [1:0]                     state;
    logic [2:0]                     led_count;
    logic                           write_strobe;
    logic [soc_pkg::word_width-1:0] write_data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= 2'd0;
            read_address <= '0;
            write_strobe <= 1'b0;
        end else begin
            state <= state + 2'd1;
            case (state)
                2'd0: begin
                    // Data arrives from the register file two edges later.
                    read_address <= soc_pkg::heartbeat_reg;
                    write_strobe <= 1'b0;
                end
                2'd2: begin
                    write_strobe <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == 2'd2) begin
            write_data <= read_data + 1'b1;
        end
    end

    assign write_port.address = soc_pkg::heartbeat_reg;
    assign write_port.write = write_strobe;
    assign write_port.data = write_data;

    // Divide by eight for the LED.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            led_count <= 3'd0;
        end else begin
            led_count <= led_count + 3'd1;
        end
    end

    assign led = led_count[2];

endmodule

`default_nettype wire

//--- design/insn_decoder.sv
`default_nettype none

module insn_decoder (
    input  riscv_pkg::insn_t    insn,
    output riscv_pkg::decode_t  decode
);

    logic [6:0] opcode;
    logic [4:0] f5;
    logic       is_fp;
    logic       fp_cvt;
    logic       fp_mv;
    logic       to_float;

    assign opcode = insn.r_fmt.opcode;
    assign f5 = insn.r_fmt.funct7[6:2];
    assign is_fp = (opcode == riscv_pkg::op_fp);

    // Converts and moves share a group, split by the direction bit.
    assign fp_cvt = is_fp && ((f5 & ~riscv_pkg::fp_dir_bit) == riscv_pkg::fcvt_f2i);
    assign fp_mv = is_fp && ((f5 | riscv_pkg::fp_dir_bit) == riscv_pkg::fmv_i2f);
    assign to_float = |(f5 & riscv_pkg::fp_dir_bit);

    // Integer opcode classes.
    assign decode.op_class.is_branch = (opcode == riscv_pkg::op_branch);
    assign decode.op_class.is_alu_reg_imm = (opcode == riscv_pkg::op_alu_imm);
    assign decode.op_class.is_alu_reg_reg = (opcode == riscv_pkg::op_alu_reg);
    assign decode.op_class.is_jal = (opcode == riscv_pkg::op_jal);
    assign decode.op_class.is_jalr = (opcode == riscv_pkg::op_jalr);
    assign decode.op_class.is_lui = (opcode == riscv_pkg::op_lui);
    assign decode.op_class.is_auipc = (opcode == riscv_pkg::op_auipc);
    assign decode.op_class.is_load = (opcode == riscv_pkg::op_load);
    assign decode.op_class.is_store = (opcode == riscv_pkg::op_store);
    assign decode.op_class.is_system = (opcode == riscv_pkg::op_system);

    // Floating point classes.
    assign decode.op_class.is_fadd = is_fp && (f5 == riscv_pkg::fadd);
    assign decode.op_class.is_fsub = is_fp && (f5 == riscv_pkg::fsub);
    assign decode.op_class.is_fmul = is_fp && (f5 == riscv_pkg::fmul);
    assign decode.op_class.is_fdiv = is_fp && (f5 == riscv_pkg::fdiv);
    assign decode.op_class.is_fsgnj = is_fp && (f5 == riscv_pkg::fsgnj);
    assign decode.op_class.is_fminmax = is_fp && (f5 == riscv_pkg::fminmax);
    assign decode.op_class.is_fsqrt = is_fp && (f5 == riscv_pkg::fsqrt);
    assign decode.op_class.is_fcmp = is_fp && (f5 == riscv_pkg::fcmp);
    assign decode.op_class.is_fcvt_f2i = fp_cvt && !to_float;
    assign decode.op_class.is_fmv_f2i = fp_mv && !to_float;
    assign decode.op_class.is_fcvt_i2f = fp_cvt && to_float;
    assign decode.op_class.is_fmv_i2f = fp_mv && to_float;

    // Register and function fields.
    assign decode.rs1 = insn.r_fmt.rs1;
    assign decode.rs2 = insn.r_fmt.rs2;
    assign decode.rs3 = insn.r4_fmt.rs3;
    assign decode.rd = insn.r_fmt.rd;
    assign decode.fmt = insn.r4_fmt.fmt;
    assign decode.funct3_rm = insn.r_fmt.funct3;
    assign decode.funct7 = insn.r_fmt.funct7;
    assign decode.funct5 = f5;
    assign decode.shamt_ftype = insn.i_fmt.imm[4:0];

    // Immediates, sign extended from bit 31.
    assign decode.imm_alu_load = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
    assign decode.imm_store = {
        {20{insn.s_fmt.imm_11_5[6]}},
        insn.s_fmt.imm_11_5,
        insn.s_fmt.imm_4_0
    };
    assign decode.imm_branch = {
        {19{insn.b_fmt.imm_12}},
        insn.b_fmt.imm_12,
        insn.b_fmt.imm_11,
        insn.b_fmt.imm_10_5,
        insn.b_fmt.imm_4_1,
        1'b0
    };
    assign decode.imm_upper = {insn.u_fmt.imm_31_12, 12'b0};
    assign decode.imm_jump = {
        {11{insn.j_fmt.imm_20}},
        insn.j_fmt.imm_20,
        insn.j_fmt.imm_19_12,
        insn.j_fmt.imm_11,
        insn.j_fmt.imm_10_1,
        1'b0
    };

endmodule

`default_nettype wire

//--- design/register_file.sv
`default_nettype none

module register_file (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  soc_pkg::reg_write_t                    write_port,
    input  logic [soc_pkg::reg_address_width-1:0]  read1_address,
    output logic [soc_pkg::word_width-1:0]         read1_data,
    input  logic [soc_pkg::reg_address_width-1:0]  read2_address,
    output logic [soc_pkg::word_width-1:0]         read2_data
);

    logic [soc_pkg::word_width-1:0] regs [0:soc_pkg::reg_count-1];

    // x0 always reads as zero.
    function automatic logic [soc_pkg::word_width-1:0] read_reg(
        input logic [soc_pkg::reg_address_width-1:0] address
    );
        return (address == '0) ? '0 : regs[address];
    endfunction

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (write_port.write && write_port.address != '0) begin
            regs[write_port.address] <= write_port.data;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read1_data <= '0;
            read2_data <= '0;
        end else begin
            read1_data <= read_reg(read1_address);
            read2_data <= read_reg(read2_address);
        end
    end

endmodule

`default_nettype wire

//--- design/block_ram.sv
`default_nettype none

module block_ram (
    input  logic                            clock,
    input  logic                            rst_n,
    input  soc_pkg::mem_port_t              port,
    output logic [soc_pkg::word_width-1:0]  read_data
);

    logic [soc_pkg::word_width-1:0] mem [0:soc_pkg::ram_depth-1];

    always_ff @(posedge clock) begin
        if (port.write) begin
            mem[port.address] <= port.data;
        end
    end

    // Read sees the word from before this edge's write.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else begin
            read_data <= mem[port.address];
        end
    end

endmodule

`default_nettype wire

//--- design/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    // Major opcodes.
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_jalr    = 7'b1100111;
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;
    localparam logic [6:0] op_system  = 7'b1110011;
    localparam logic [6:0] op_fp      = 7'b1010011;

    // Upper five bits of funct7 under op_fp.
    localparam logic [4:0] fadd     = 5'b00000;
    localparam logic [4:0] fsub     = 5'b00001;
    localparam logic [4:0] fmul     = 5'b00010;
    localparam logic [4:0] fdiv     = 5'b00011;
    localparam logic [4:0] fsgnj    = 5'b00100;
    localparam logic [4:0] fminmax  = 5'b00101;
    localparam logic [4:0] fsqrt    = 5'b01011;
    localparam logic [4:0] fcmp     = 5'b10100;
    localparam logic [4:0] fcvt_f2i = 5'b11000;
    localparam logic [4:0] fmv_f2i  = 5'b11100;
    localparam logic [4:0] fcvt_i2f = 5'b11010;
    localparam logic [4:0] fmv_i2f  = 5'b11110;

    // Set when the move or convert goes from integer to float.
    localparam logic [4:0] fp_dir_bit = fcvt_f2i ^ fcvt_i2f;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [4:0] rs3;
            logic [1:0] fmt;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r4_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } insn_t;

    typedef struct packed {
        logic is_branch;
        logic is_alu_reg_imm;
        logic is_alu_reg_reg;
        logic is_jal;
        logic is_jalr;
        logic is_lui;
        logic is_auipc;
        logic is_load;
        logic is_store;
        logic is_system;
        logic is_fadd;
        logic is_fsub;
        logic is_fmul;
        logic is_fdiv;
        logic is_fsgnj;
        logic is_fminmax;
        logic is_fsqrt;
        logic is_fcmp;
        logic is_fcvt_f2i;
        logic is_fmv_f2i;
        logic is_fcvt_i2f;
        logic is_fmv_i2f;
    } op_class_t;

    typedef struct packed {
        op_class_t   op_class;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rs3;
        logic [4:0]  rd;
        logic [1:0]  fmt;
        logic [2:0]  funct3_rm;
        logic [6:0]  funct7;
        logic [4:0]  funct5;
        logic [4:0]  shamt_ftype;
        logic [31:0] imm_alu_load;
        logic [31:0] imm_store;
        logic [31:0] imm_branch;
        logic [31:0] imm_upper;
        logic [31:0] imm_jump;
    } decode_t;

endpackage

`default_nettype wire

//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

    localparam int word_width = 32;
    localparam int ram_address_width = 16;
    localparam int reg_address_width = 5;

    localparam int ram_depth = 1 << ram_address_width;
    localparam int reg_count = 1 << reg_address_width;

    // Register bumped by the heartbeat loop.
    localparam logic [reg_address_width-1:0] heartbeat_reg = 5'd1;

    // External RAM load and inspect port.
    typedef struct packed {
        logic [ram_address_width-1:0] address;
        logic                         write;
        logic [word_width-1:0]        data;
    } mem_port_t;

    typedef struct packed {
        logic [reg_address_width-1:0] address;
        logic                         write;
        logic [word_width-1:0]        data;
    } reg_write_t;

endpackage

`default_nettype wire
